// ==== Bender.yml ====
package:
  name: cache_store

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/cache_pkg.sv
      - logic/victim_if.sv
      - logic/way_lookup.sv
      - logic/plru_tree.sv
      - logic/cache_array.sv
      - logic/victim_fifo.sv
      - logic/cache_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_cache_top.sv

// ==== files.f ====
+incdir+logic
logic/cache_pkg.sv
logic/victim_if.sv
logic/way_lookup.sv
logic/plru_tree.sv
logic/cache_array.sv
logic/victim_fifo.sv
logic/cache_top.sv
verif/tb_cache_top.sv

// ==== logic/cache_array.sv ====
// cache array with line storage, read and write ports, allocation and eviction
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_array (
	input logic clock,
	input logic reset,
	input logic rd_en,
	input cache_pkg::set_idx_t rd_idx,
	input cache_pkg::tag_t rd_tag,
	output logic [`CACHE_DATA_BITS-1:0] rd_data,
	output logic rd_valid,
	output logic rd_miss,
	input logic wr_en,
	input cache_pkg::set_idx_t wr_idx,
	input cache_pkg::tag_t wr_tag,
	input logic [`CACHE_DATA_BITS-1:0] wr_data,
	output logic wr_miss,
	victim_if.source victim
);
	import cache_pkg::*;

	cache_line_t [`CACHE_NUM_SETS-1:0][`CACHE_NUM_WAYS-1:0] lines;

	logic rd_hit;
	way_idx_t rd_hit_way;

	logic wr_hit;
	way_idx_t wr_hit_way;
	logic wr_has_free;
	way_idx_t wr_free_way;

	way_idx_t plru_way;
	way_idx_t wr_way;
	logic wr_evict;
	logic wr_do;
	logic rd_fwd;

	way_lookup rd_lookup (
		.set_lines(lines[rd_idx]),
		.tag(rd_tag),
		.hit(rd_hit),
		.hit_way(rd_hit_way),
		.has_free(),
		.free_way()
	);

	way_lookup wr_lookup (
		.set_lines(lines[wr_idx]),
		.tag(wr_tag),
		.hit(wr_hit),
		.hit_way(wr_hit_way),
		.has_free(wr_has_free),
		.free_way(wr_free_way)
	);

	plru_tree plru (
		.clock(clock),
		.reset(reset),
		.rd_touch(rd_en && rd_hit),
		.rd_idx(rd_idx),
		.rd_way(rd_hit_way),
		.wr_touch(wr_do),
		.wr_idx(wr_idx),
		.wr_way(wr_way),
		.victim_way(plru_way)
	);

	// write side
	assign wr_miss = wr_en && !wr_hit;
	assign wr_evict = wr_miss && !wr_has_free;
	// a replacing write is dropped while the buffer cannot take the victim
	assign wr_do = wr_en && !(wr_evict && victim.full);
	assign wr_way = wr_hit ? wr_hit_way : (wr_has_free ? wr_free_way : plru_way);

	assign victim.push = wr_evict && !victim.full;
	assign victim.line = lines[wr_idx][plru_way];
	assign victim.set_idx = wr_idx;

	// read side, same-cycle write forwarded
	assign rd_fwd = rd_en && wr_do && (rd_idx == wr_idx) && (rd_tag == wr_tag);
	assign rd_valid = rd_en && (rd_fwd || rd_hit);
	assign rd_miss = rd_en && !rd_valid;
	assign rd_data = rd_fwd ? wr_data : lines[rd_idx][rd_hit_way].data;

	always_ff @(posedge clock) begin
		if (reset) begin
			lines <= '0;
		end else if (wr_do) begin
			// every written line is dirty
			lines[wr_idx][wr_way] <= '{valid: 1'b1, dirty: 1'b1, tag: wr_tag, data: wr_data};
		end
	end

	// environment holds off replacing writes until the buffer drains
	replace_while_full: assert property (
		@(posedge clock) disable iff (reset) !(wr_evict && victim.full)
	) else $error("replacing write to set %0d while write-back buffer full", wr_idx);

endmodule

`default_nettype wire

// ==== logic/cache_defs.svh ====
// cache sizing macros for sets, ways, tag, line data and write-back depth
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// number of sets in the array
`define CACHE_NUM_SETS 8

// ways per set, must be a power of two
`define CACHE_NUM_WAYS 4

// tag field width
`define CACHE_TAG_BITS 8

// line payload width
`define CACHE_DATA_BITS 64

// write-back buffer entries
`define CACHE_VICTIM_DEPTH 4

`endif

// ==== logic/cache_pkg.sv ====
// cache package with the line record and the index types shared by the cache
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

	localparam int SET_BITS = $clog2(`CACHE_NUM_SETS);
	localparam int WAY_BITS = $clog2(`CACHE_NUM_WAYS);

	typedef logic [SET_BITS-1:0] set_idx_t;
	typedef logic [WAY_BITS-1:0] way_idx_t;
	typedef logic [`CACHE_TAG_BITS-1:0] tag_t;

	// one stored line
	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
		logic [`CACHE_DATA_BITS-1:0] data;
	} cache_line_t;

endpackage

`default_nettype wire

// ==== logic/cache_top.sv ====
// cache top level joining the line array and the write-back buffer
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module cache_top (
	input logic clock,
	input logic reset,
	input logic rd_en,
	input cache_pkg::set_idx_t rd_idx,
	input cache_pkg::tag_t rd_tag,
	output logic [`CACHE_DATA_BITS-1:0] rd_data,
	output logic rd_valid,
	output logic rd_miss,
	input logic wr_en,
	input cache_pkg::set_idx_t wr_idx,
	input cache_pkg::tag_t wr_tag,
	input logic [`CACHE_DATA_BITS-1:0] wr_data,
	output logic wr_miss,
	output logic wb_valid,
	output cache_pkg::tag_t wb_tag,
	output cache_pkg::set_idx_t wb_idx,
	output logic [`CACHE_DATA_BITS-1:0] wb_data,
	output logic wb_full,
	input logic wb_taken
);
	import cache_pkg::*;

	cache_line_t head_line;

	victim_if victim_bus ();

	cache_array array_inst (
		.clock(clock),
		.reset(reset),
		.rd_en(rd_en),
		.rd_idx(rd_idx),
		.rd_tag(rd_tag),
		.rd_data(rd_data),
		.rd_valid(rd_valid),
		.rd_miss(rd_miss),
		.wr_en(wr_en),
		.wr_idx(wr_idx),
		.wr_tag(wr_tag),
		.wr_data(wr_data),
		.wr_miss(wr_miss),
		.victim(victim_bus.source)
	);

	victim_fifo fifo_inst (
		.clock(clock),
		.reset(reset),
		.victim(victim_bus.sink),
		.taken(wb_taken),
		.head_valid(wb_valid),
		.head_line(head_line),
		.head_idx(wb_idx),
		.full(wb_full)
	);

	// line fields out to memory
	assign wb_tag = head_line.tag;
	assign wb_data = head_line.data;

endmodule

`default_nettype wire

// ==== logic/plru_tree.sv ====
// pseudo-LRU tree per set with two touch ports and victim way selection
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module plru_tree (
	input logic clock,
	input logic reset,
	input logic rd_touch,
	input cache_pkg::set_idx_t rd_idx,
	input cache_pkg::way_idx_t rd_way,
	input logic wr_touch,
	input cache_pkg::set_idx_t wr_idx,
	input cache_pkg::way_idx_t wr_way,
	output cache_pkg::way_idx_t victim_way
);
	import cache_pkg::*;

	localparam int LEVELS = $clog2(`CACHE_NUM_WAYS);

	typedef logic [`CACHE_NUM_WAYS-2:0] tree_bits_t;

	tree_bits_t [`CACHE_NUM_SETS-1:0] tree;
	tree_bits_t [`CACHE_NUM_SETS-1:0] tree_next;

	// node n has children 2n+1 (lower half) and 2n+2 (upper half)
	function automatic tree_bits_t touch(input tree_bits_t bits, input way_idx_t way);
		tree_bits_t t;
		int node;
		t = bits;
		node = 0;
		for (int lvl = LEVELS - 1; lvl >= 0; lvl--) begin
			// point away from the touched half
			t[node] = ~way[lvl];
			node = 2 * node + 1 + int'(way[lvl]);
		end
		return t;
	endfunction

	function automatic way_idx_t pick(input tree_bits_t bits);
		way_idx_t w;
		int node;
		w = '0;
		node = 0;
		for (int lvl = LEVELS - 1; lvl >= 0; lvl--) begin
			w[lvl] = bits[node];
			node = 2 * node + 1 + int'(bits[node]);
		end
		return w;
	endfunction

	// read touch first, write touch on top of it
	always_comb begin
		tree_next = tree;
		if (rd_touch)
			tree_next[rd_idx] = touch(tree_next[rd_idx], rd_way);
		if (wr_touch)
			tree_next[wr_idx] = touch(tree_next[wr_idx], wr_way);
	end

	assign victim_way = pick(tree[wr_idx]);

	always_ff @(posedge clock) begin
		if (reset)
			tree <= '0;
		else
			tree <= tree_next;
	end

endmodule

`default_nettype wire

// ==== logic/victim_fifo.sv ====
// write-back buffer holding evicted lines until memory takes them
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module victim_fifo (
	input logic clock,
	input logic reset,
	victim_if.sink victim,
	input logic taken,
	output logic head_valid,
	output cache_pkg::cache_line_t head_line,
	output cache_pkg::set_idx_t head_idx,
	output logic full
);
	import cache_pkg::*;

	localparam int DEPTH = `CACHE_VICTIM_DEPTH;
	localparam int PTR_BITS = $clog2(DEPTH);
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	cache_line_t mem_line [DEPTH];
	set_idx_t mem_idx [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic push;
	logic pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign head_valid = (count != '0);
	assign full = (count == CNT_BITS'(DEPTH));
	assign victim.full = full;

	assign push = victim.push && !full;
	assign pop = taken && head_valid;

	assign head_line = mem_line[rd_ptr];
	assign head_idx = mem_idx[rd_ptr];

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// entry payload
	always_ff @(posedge clock) begin
		if (push) begin
			mem_line[wr_ptr] <= victim.line;
			mem_idx[wr_ptr] <= victim.set_idx;
		end
	end

	no_push_when_full: assert property (
		@(posedge clock) disable iff (reset) !(victim.push && full)
	) else $error("victim pushed into a full write-back buffer");

	no_pop_when_empty: assert property (
		@(posedge clock) disable iff (reset) !(taken && !head_valid)
	) else $error("write-back taken with no line pending");

endmodule

`default_nettype wire

// ==== logic/victim_if.sv ====
// victim interface carrying one evicted line from the array to the write-back buffer
`timescale 1ns/100ps
`default_nettype none

interface victim_if;
	import cache_pkg::*;

	// one-cycle strobe with the evicted line
	logic push;
	cache_line_t line;
	set_idx_t set_idx;

	// level from the buffer
	logic full;

	modport source (
		output push,
		output line,
		output set_idx,
		input full
	);

	modport sink (
		input push,
		input line,
		input set_idx,
		output full
	);

endinterface

`default_nettype wire

// ==== logic/way_lookup.sv ====
// way lookup, tag compare across one set giving hit way and lowest free way
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module way_lookup (
	input cache_pkg::cache_line_t [`CACHE_NUM_WAYS-1:0] set_lines,
	input cache_pkg::tag_t tag,
	output logic hit,
	output cache_pkg::way_idx_t hit_way,
	output logic has_free,
	output cache_pkg::way_idx_t free_way
);
	import cache_pkg::*;

	logic [`CACHE_NUM_WAYS-1:0] match;

	always_comb begin
		match = '0;
		hit_way = '0;
		has_free = 1'b0;
		free_way = '0;
		// walk downward so the lowest way wins
		for (int w = `CACHE_NUM_WAYS - 1; w >= 0; w--) begin
			match[w] = set_lines[w].valid && (set_lines[w].tag == tag);
			if (match[w])
				hit_way = way_idx_t'(w);
			if (!set_lines[w].valid) begin
				has_free = 1'b1;
				free_way = way_idx_t'(w);
			end
		end
	end

	assign hit = |match;

	// allocation must never leave a tag in two ways of a set
	always_comb begin
		assert #0 ($isunknown(match) || $onehot0(match))
			else $error("tag %0h matches more than one valid way", tag);
	end

endmodule

`default_nettype wire

// ==== verif/tb_cache_top.sv ====
// cache testbench, table-driven stimulus with a replacement and write-back model
`timescale 1ns/100ps
`default_nettype none

`include "cache_defs.svh"

module tb_cache_top;
	import cache_pkg::*;

	localparam int PERIOD = 8;
	localparam int WAYS = `CACHE_NUM_WAYS;
	localparam int SETS = `CACHE_NUM_SETS;
	localparam int DB = `CACHE_DATA_BITS;

	typedef logic [WAYS-2:0] tree_t;

	// one table row, stimulus then expected outputs
	typedef struct {
		logic re;
		int ri;
		int rt;
		logic we;
		int wi;
		int wt;
		int ws;
		logic tk;
		logic ev;
		int es;
		logic em;
		logic ew;
	} row_t;

	typedef struct {
		tag_t tag;
		set_idx_t idx;
		logic [DB-1:0] data;
	} victim_t;

	logic clock;
	logic reset;
	logic rd_en;
	set_idx_t rd_idx;
	tag_t rd_tag;
	logic [DB-1:0] rd_data;
	logic rd_valid;
	logic rd_miss;
	logic wr_en;
	set_idx_t wr_idx;
	tag_t wr_tag;
	logic [DB-1:0] wr_data;
	logic wr_miss;
	logic wb_valid;
	tag_t wb_tag;
	set_idx_t wb_idx;
	logic [DB-1:0] wb_data;
	logic wb_full;
	logic wb_taken;

	row_t rows[$];
	victim_t expect_q[$];
	logic [DB-1:0] pool [16];
	logic table_ready;
	int errors;
	int checks;

	// model state
	logic m_valid [SETS][WAYS];
	tag_t m_tag [SETS][WAYS];
	logic [DB-1:0] m_data [SETS][WAYS];
	tree_t m_tree [SETS];

	cache_top cache_top_inst (
		.clock(clock), .reset(reset),
		.rd_en(rd_en), .rd_idx(rd_idx), .rd_tag(rd_tag),
		.rd_data(rd_data), .rd_valid(rd_valid), .rd_miss(rd_miss),
		.wr_en(wr_en), .wr_idx(wr_idx), .wr_tag(wr_tag), .wr_data(wr_data),
		.wr_miss(wr_miss),
		.wb_valid(wb_valid), .wb_tag(wb_tag), .wb_idx(wb_idx), .wb_data(wb_data),
		.wb_full(wb_full), .wb_taken(wb_taken)
	);

	always #(PERIOD / 2) clock = ~clock;

	task automatic add_row(input logic re, input int ri, input int rt, input logic we,
			input int wi, input int wt, input int ws, input logic tk, input logic ev,
			input int es, input logic em, input logic ew);
		row_t r;
		r = '{re, ri, rt, we, wi, wt, ws, tk, ev, es, em, ew};
		rows.push_back(r);
	endtask

	task automatic flag_mismatch(input int row, input string field,
			input logic [DB-1:0] got, input logic [DB-1:0] want);
		errors++;
		$display("ERR %0t: row %0d %s is %0h, expected %0h", $time, row, field, got, want);
	endtask

	// ways lo..lo+size-1 under each node, lower half on the left
	function automatic tree_t touch_way(input tree_t bits, input int way);
		tree_t t;
		int node;
		int lo;
		int size;
		t = bits;
		node = 0;
		lo = 0;
		size = WAYS;
		while (size > 1) begin
			size = size / 2;
			if (way < lo + size) begin
				t[node] = 1'b1;
				node = 2 * node + 1;
			end else begin
				t[node] = 1'b0;
				lo = lo + size;
				node = 2 * node + 2;
			end
		end
		return t;
	endfunction

	function automatic int pick_way(input tree_t bits);
		int node;
		int lo;
		int size;
		node = 0;
		lo = 0;
		size = WAYS;
		while (size > 1) begin
			size = size / 2;
			if (bits[node]) begin
				lo = lo + size;
				node = 2 * node + 2;
			end else begin
				node = 2 * node + 1;
			end
		end
		return lo;
	endfunction

	function automatic int find_way(input int set, input int tag);
		for (int w = 0; w < WAYS; w++)
			if (m_valid[set][w] && m_tag[set][w] == tag_t'(tag))
				return w;
		return -1;
	endfunction

	function automatic int lowest_free(input int set);
		for (int w = 0; w < WAYS; w++)
			if (!m_valid[set][w])
				return w;
		return -1;
	endfunction

	// state after the coming edge
	task automatic model_step(input row_t r);
		int rd_way;
		int wr_way;
		logic evict;
		logic was_full;
		victim_t v;
		rd_way = r.re ? find_way(r.ri, r.rt) : -1;
		wr_way = -1;
		evict = 1'b0;
		was_full = (expect_q.size() == `CACHE_VICTIM_DEPTH);
		if (r.we) begin
			wr_way = find_way(r.wi, r.wt);
			if (wr_way < 0)
				wr_way = lowest_free(r.wi);
			if (wr_way < 0) begin
				wr_way = pick_way(m_tree[r.wi]);
				evict = 1'b1;
				v = '{m_tag[r.wi][wr_way], set_idx_t'(r.wi), m_data[r.wi][wr_way]};
			end
		end
		if (r.tk && expect_q.size() > 0)
			void'(expect_q.pop_front());
		if (rd_way >= 0)
			m_tree[r.ri] = touch_way(m_tree[r.ri], rd_way);
		if (r.we && !(evict && was_full)) begin
			m_valid[r.wi][wr_way] = 1'b1;
			m_tag[r.wi][wr_way] = tag_t'(r.wt);
			m_data[r.wi][wr_way] = pool[r.ws];
			m_tree[r.wi] = touch_way(m_tree[r.wi], wr_way);
			if (evict)
				expect_q.push_back(v);
		end
	endtask

	task automatic check_row(input int i, input row_t r);
		checks += 5;
		assert (rd_valid === r.ev) else flag_mismatch(i, "rd_valid", rd_valid, r.ev);
		assert (rd_miss === r.em) else flag_mismatch(i, "rd_miss", rd_miss, r.em);
		assert (wr_miss === r.ew) else flag_mismatch(i, "wr_miss", wr_miss, r.ew);
		assert (wb_valid === (expect_q.size() != 0))
			else flag_mismatch(i, "wb_valid", wb_valid, expect_q.size() != 0);
		assert (wb_full === (expect_q.size() == `CACHE_VICTIM_DEPTH))
			else flag_mismatch(i, "wb_full", wb_full, expect_q.size() == `CACHE_VICTIM_DEPTH);
		if (r.ev) begin
			checks++;
			assert (rd_data === pool[r.es]) else flag_mismatch(i, "rd_data", rd_data, pool[r.es]);
		end
		if (r.tk) begin
			if (expect_q.size() == 0) begin
				errors++;
				$display("row %0d drains the write-back buffer but no eviction is pending", i);
			end else begin
				checks += 3;
				assert (wb_tag === expect_q[0].tag)
					else flag_mismatch(i, "wb_tag", wb_tag, expect_q[0].tag);
				assert (wb_idx === expect_q[0].idx)
					else flag_mismatch(i, "wb_idx", wb_idx, expect_q[0].idx);
				assert (wb_data === expect_q[0].data)
					else flag_mismatch(i, "wb_data", wb_data, expect_q[0].data);
			end
		end
	endtask

	task automatic build_table();
		// re ri rt | we wi wt slot | taken | rd_valid slot rd_miss wr_miss
		add_row(1, 3, 'h10, 0, 0, 0, 0, 0, 0, 0, 1, 0);
		add_row(1, 5, 'h20, 0, 0, 0, 0, 0, 0, 0, 1, 0);
		// fill ways 0 to 3 of set 3
		add_row(0, 0, 0, 1, 3, 'h10, 0, 0, 0, 0, 0, 1);
		add_row(0, 0, 0, 1, 3, 'h11, 1, 0, 0, 0, 0, 1);
		add_row(0, 0, 0, 1, 3, 'h12, 2, 0, 0, 0, 0, 1);
		add_row(0, 0, 0, 1, 3, 'h13, 3, 0, 0, 0, 0, 1);
		add_row(1, 3, 'h10, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		add_row(1, 3, 'h11, 0, 0, 0, 0, 0, 1, 1, 0, 0);
		add_row(1, 3, 'h12, 0, 0, 0, 0, 0, 1, 2, 0, 0);
		add_row(1, 3, 'h13, 0, 0, 0, 0, 0, 1, 3, 0, 0);
		// same-cycle write hit forwarded to the read
		add_row(1, 3, 'h12, 1, 3, 'h12, 4, 0, 1, 4, 0, 0);
		add_row(1, 3, 'h12, 0, 0, 0, 0, 0, 1, 4, 0, 0);
		add_row(1, 3, 'h10, 0, 0, 0, 0, 0, 1, 0, 0, 0);
		// tree now points at way 3
		add_row(0, 0, 0, 1, 3, 'h14, 5, 0, 0, 0, 0, 1);
		add_row(1, 3, 'h13, 0, 0, 0, 0, 0, 0, 0, 1, 0);
		add_row(1, 3, 'h14, 0, 0, 0, 0, 1, 1, 5, 0, 0);
		add_row(1, 3, 'h11, 0, 0, 0, 0, 0, 1, 1, 0, 0);
		// four evictions fill the buffer
		add_row(0, 0, 0, 1, 3, 'h15, 6, 0, 0, 0, 0, 1);
		add_row(0, 0, 0, 1, 3, 'h16, 7, 0, 0, 0, 0, 1);
		add_row(0, 0, 0, 1, 3, 'h17, 8, 0, 0, 0, 0, 1);
		add_row(0, 0, 0, 1, 3, 'h18, 9, 0, 0, 0, 0, 1);
		add_row(1, 3, 'h18, 1, 3, 'h15, 10, 0, 1, 9, 0, 0);
		add_row(0, 0, 0, 1, 5, 'h20, 11, 1, 0, 0, 0, 1);
		add_row(1, 5, 'h20, 0, 0, 0, 0, 1, 1, 11, 0, 0);
		add_row(1, 3, 'h15, 0, 0, 0, 0, 1, 1, 10, 0, 0);
		add_row(1, 3, 'h10, 0, 0, 0, 0, 1, 0, 0, 1, 0);
		add_row(1, 5, 'h21, 0, 0, 0, 0, 0, 0, 0, 1, 0);
	endtask

	initial begin
		wait (table_ready);
		#(rows.size() * PERIOD + 200);
		$display("timeout, the table did not finish in time");
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		table_ready = 1'b0;
		clock = 1'b0;
		reset = 1'b1;
		rd_en = 1'b0;
		rd_idx = '0;
		rd_tag = '0;
		wr_en = 1'b0;
		wr_idx = '0;
		wr_tag = '0;
		wr_data = '0;
		wb_taken = 1'b0;
		errors = 0;
		checks = 0;
		void'($urandom(32'hf716));
		for (int k = 0; k < 16; k++)
			pool[k] = {$urandom, $urandom};
		for (int s = 0; s < SETS; s++) begin
			m_tree[s] = '0;
			for (int w = 0; w < WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w] = '0;
				m_data[s][w] = '0;
			end
		end
		build_table();
		table_ready = 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			@(posedge clock);
			rd_en <= rows[i].re;
			rd_idx <= set_idx_t'(rows[i].ri);
			rd_tag <= tag_t'(rows[i].rt);
			wr_en <= rows[i].we;
			wr_idx <= set_idx_t'(rows[i].wi);
			wr_tag <= tag_t'(rows[i].wt);
			wr_data <= rows[i].we ? pool[rows[i].ws] : '0;
			wb_taken <= rows[i].tk;
			@(negedge clock);
			check_row(i, rows[i]);
			model_step(rows[i]);
		end
		@(posedge clock);
		rd_en <= 1'b0;
		wr_en <= 1'b0;
		wb_taken <= 1'b0;
		@(negedge clock);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
